// ==== memAddrDecode.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module memAddrDecode (
	input logic clk,
	input logic rst,
	input logic [15:0] pc,
	input logic [15:0] address,
	input logic [15:0] writeData,
	input logic memRead,
	input logic memWrite,
	input logic accessDone,
	output memSysPkg::bankReqT bankReq [`BANK_COUNT],
	output memSysPkg::uartReqT uartReq,
	output memSysPkg::accessT target,
	output logic conflict
);
	import memSysPkg::*;

	logic startPending;
	logic openCycle;
	logic isAccess;
	logic isRam1;
	logic isUart;
	logic isComCmd;

	// A new cycle opens after reset and after every accessDone
	assign openCycle = startPending | accessDone;
	assign isAccess = memRead | memWrite;
	assign isRam1 = address < `RAM1_UPPER;
	assign isComCmd = (address == `COM1_COMMAND) || (address == `COM2_COMMAND);
	assign isUart = isComCmd || (address == `COM1_DATA) || (address == `COM2_DATA);

	always_ff @(posedge clk) begin
		if (!rst) begin
			startPending <= 1'b1;
			for (int i = 0; i < `BANK_COUNT; i++) begin
				bankReq[i].valid <= 1'b0;
			end
			uartReq.valid <= 1'b0;
			target <= accNone;
			conflict <= 1'b0;
		end else begin
			startPending <= 1'b0;
			// Strobes last a single cycle
			for (int i = 0; i < `BANK_COUNT; i++) begin
				bankReq[i].valid <= 1'b0;
			end
			uartReq.valid <= 1'b0;
			if (openCycle) begin
				// Bank 0 serves data in its range, the fetch otherwise
				bankReq[0].valid <= 1'b1;
				bankReq[0].data <= writeData;
				if (isAccess && isRam1) begin
					bankReq[0].write <= memWrite;
					bankReq[0].addr <= {{(`SRAM_ADDR_W - 16){1'b0}}, address};
				end else begin
					bankReq[0].write <= 1'b0;
					bankReq[0].addr <= {{(`SRAM_ADDR_W - 16){1'b0}}, pc};
				end
				bankReq[1].valid <= isAccess && !isRam1 && !isUart;
				bankReq[1].write <= memWrite;
				bankReq[1].addr <= {{(`SRAM_ADDR_W - 16){1'b0}}, address};
				bankReq[1].data <= writeData;
				uartReq.valid <= isAccess && !isRam1 && isUart;
				uartReq.write <= memWrite;
				uartReq.isCommand <= isComCmd;
				uartReq.data <= writeData[7:0];
				conflict <= isAccess && (isRam1 || isUart);
				if (!isAccess)
					target <= accNone;
				else if (isRam1)
					target <= accBank0;
				else if (isUart)
					target <= accUart;
				else
					target <= accBank1;
			end
		end
	end

endmodule

// ==== memRespMerge.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module memRespMerge (
	input logic clk,
	input logic rst,
	input memSysPkg::accessT target,
	input logic conflict,
	input memSysPkg::bankRespT bankResp [`BANK_COUNT],
	input memSysPkg::uartRespT uartResp,
	input memSysPkg::uartReqT uartReq,
	output logic [15:0] readData,
	output logic [15:0] instruct,
	output logic memConflict,
	output logic noStop,
	output logic accessDone
);
	import memSysPkg::*;

	logic gotBank0;
	logic gotBank1;
	logic gotUart;
	logic allDone;

	// Bank 0 always runs, for data or for the fetch
	assign allDone = (gotBank0 | bankResp[0].done)
		& ((target != accBank1) | gotBank1 | bankResp[1].done)
		& ((target != accUart) | gotUart | uartResp.done);

	assign memConflict = conflict;

	always_ff @(posedge clk) begin
		if (!rst) begin
			gotBank0 <= 1'b0;
			gotBank1 <= 1'b0;
			gotUart <= 1'b0;
			accessDone <= 1'b0;
			noStop <= 1'b1;
		end else begin
			accessDone <= allDone;
			gotBank0 <= !allDone & (gotBank0 | bankResp[0].done);
			gotBank1 <= !allDone & (gotBank1 | bankResp[1].done);
			gotUart <= !allDone & (gotUart | uartResp.done);
			// CPU stalls only for serial data transfers
			if (uartReq.valid && !uartReq.isCommand)
				noStop <= 1'b0;
			else if (uartResp.done)
				noStop <= 1'b1;
			if (bankResp[0].done)
				instruct <= conflict ? `NOP_INSTR : bankResp[0].data;
			case (target)
				accBank0: if (bankResp[0].done) readData <= bankResp[0].data;
				accBank1: if (bankResp[1].done) readData <= bankResp[1].data;
				accUart: if (uartResp.done) readData <= uartResp.data;
				default: ;
			endcase
		end
	end

endmodule

// ==== memSys.f ====
+incdir+.
memSysPkg.sv
memAddrDecode.sv
sramBankCtrl.sv
uartPortCtrl.sv
memRespMerge.sv
memSys.sv
memSys_tbModels.sv
memSys_tb.sv

// ==== memSys.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module memSys (
	input logic clk,
	input logic rst,
	input logic [15:0] pc,
	input logic [15:0] address,
	input logic [15:0] writeData,
	input logic memRead,
	input logic memWrite,
	output logic [15:0] readData,
	output logic [15:0] instruct,
	output logic memConflict,
	output logic noStop,
	output logic accessDone,
	// Program and low data chip
	output logic [`SRAM_ADDR_W-1:0] ram1Addr,
	output logic [15:0] ram1Dout,
	output logic ram1Doe,
	input logic [15:0] ram1Din,
	output logic ram1En,
	output logic ram1Oe,
	output logic ram1We,
	// High data chip
	output logic [`SRAM_ADDR_W-1:0] ram2Addr,
	output logic [15:0] ram2Dout,
	output logic ram2Doe,
	input logic [15:0] ram2Din,
	output logic ram2En,
	output logic ram2Oe,
	output logic ram2We,
	// Serial port
	output logic [7:0] uartDout,
	output logic uartDoe,
	output logic rdn,
	output logic wrn,
	input logic [7:0] uartDin,
	input logic dataReady,
	input logic tbre,
	input logic tsre
);
	import memSysPkg::*;

	bankReqT bankReq [`BANK_COUNT];
	bankRespT bankResp [`BANK_COUNT];
	uartReqT uartReq;
	uartRespT uartResp;
	accessT target;
	logic conflict;

	logic [`SRAM_ADDR_W-1:0] sramAddr [`BANK_COUNT];
	logic [15:0] sramDout [`BANK_COUNT];
	logic [15:0] sramDin [`BANK_COUNT];
	logic sramDoe [`BANK_COUNT];
	logic sramEn [`BANK_COUNT];
	logic sramOe [`BANK_COUNT];
	logic sramWe [`BANK_COUNT];

	memAddrDecode memAddrDecode_inst (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.address(address),
		.writeData(writeData),
		.memRead(memRead),
		.memWrite(memWrite),
		.accessDone(accessDone),
		.bankReq(bankReq),
		.uartReq(uartReq),
		.target(target),
		.conflict(conflict)
	);

	//////////////////////////////
	// SRAM banks
	//////////////////////////////

	for (genvar i = 0; i < `BANK_COUNT; i++) begin : genBank
		sramBankCtrl sramBankCtrl_inst (
			.clk(clk),
			.rst(rst),
			.req(bankReq[i]),
			.resp(bankResp[i]),
			.sramAddr(sramAddr[i]),
			.sramDout(sramDout[i]),
			.sramDoe(sramDoe[i]),
			.sramEn(sramEn[i]),
			.sramOe(sramOe[i]),
			.sramWe(sramWe[i]),
			.sramDin(sramDin[i])
		);
	end

	assign ram1Addr = sramAddr[0];
	assign ram1Dout = sramDout[0];
	assign ram1Doe = sramDoe[0];
	assign ram1En = sramEn[0];
	assign ram1Oe = sramOe[0];
	assign ram1We = sramWe[0];
	assign sramDin[0] = ram1Din;
	assign ram2Addr = sramAddr[1];
	assign ram2Dout = sramDout[1];
	assign ram2Doe = sramDoe[1];
	assign ram2En = sramEn[1];
	assign ram2Oe = sramOe[1];
	assign ram2We = sramWe[1];
	assign sramDin[1] = ram2Din;

	uartPortCtrl uartPortCtrl_inst (
		.clk(clk),
		.rst(rst),
		.req(uartReq),
		.resp(uartResp),
		.uartDout(uartDout),
		.uartDoe(uartDoe),
		.rdn(rdn),
		.wrn(wrn),
		.uartDin(uartDin),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

	memRespMerge memRespMerge_inst (
		.clk(clk),
		.rst(rst),
		.target(target),
		.conflict(conflict),
		.bankResp(bankResp),
		.uartResp(uartResp),
		.uartReq(uartReq),
		.readData(readData),
		.instruct(instruct),
		.memConflict(memConflict),
		.noStop(noStop),
		.accessDone(accessDone)
	);

endmodule

// ==== memSysPkg.sv ====
`include "memSys_defines.svh"

package memSysPkg;

	// One access to one SRAM chip
	typedef struct packed {
		logic valid;
		logic write;
		logic [`SRAM_ADDR_W-1:0] addr;
		logic [15:0] data;
	} bankReqT;

	typedef struct packed {
		logic done;
		logic [15:0] data;
	} bankRespT;

	// One access to the serial port
	typedef struct packed {
		logic valid;
		logic write;
		logic isCommand;
		logic [7:0] data;
	} uartReqT;

	typedef struct packed {
		logic done;
		logic [15:0] data;
	} uartRespT;

	// Unit that answers the data access of a cycle
	typedef enum logic [1:0] {
		accNone,
		accBank0,
		accBank1,
		accUart
	} accessT;

	typedef struct packed {
		logic [13:0] reserved;
		logic readReady;
		logic writeReady;
	} uartStatusFlagsT;

	// Built by flags, read back as a data word
	typedef union packed {
		logic [15:0] raw;
		uartStatusFlagsT flags;
	} uartStatusU;

endpackage

// ==== memSys_defines.svh ====
`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

//////////////////////////////
// Address map
//////////////////////////////

// Data below this bound lives in the program chip
`define RAM1_UPPER 16'h8000

// Serial port registers
`define COM1_DATA 16'hBF00
`define COM1_COMMAND 16'hBF01
`define COM2_DATA 16'hBF02
`define COM2_COMMAND 16'hBF03

//////////////////////////////
// Memory geometry
//////////////////////////////

`define BANK_COUNT 2
`define SRAM_ADDR_W 18

// Fetch word returned when bank 0 is busy with data
`define NOP_INSTR 16'h0800

// Status word codes for a command read
`define STATUS_WRITE 16'd1
`define STATUS_READ 16'd2
`define STATUS_BOTH 16'd3

// Cycles that rdn or wrn stay low
`define UART_STROBE_CYCLES 4

`endif

// ==== memSys_tb.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module memSys_tb;

	localparam int accessTimeout = 50;

	logic clk;
	logic rst;
	logic [15:0] pc;
	logic [15:0] address;
	logic [15:0] writeData;
	logic memRead;
	logic memWrite;
	logic [15:0] readData;
	logic [15:0] instruct;
	logic memConflict;
	logic noStop;
	logic accessDone;
	logic [`SRAM_ADDR_W-1:0] ram1Addr, ram2Addr;
	logic [15:0] ram1Dout, ram1Din, ram2Dout, ram2Din;
	logic ram1Doe, ram1En, ram1Oe, ram1We;
	logic ram2Doe, ram2En, ram2Oe, ram2We;
	logic [7:0] uartDout, uartDin;
	logic uartDoe, rdn, wrn;
	logic dataReady, tbre, tsre;

	// UART model stimulus and observation
	logic rxReady;
	logic [7:0] rxByte;
	logic [7:0] txLast;
	int txCount;

	// Reference model state
	logic [15:0] refRam1 [65536];
	logic [15:0] refRam2 [65536];
	logic [7:0] txSent [$];

	logic [31:0] lcgState = 32'h1e41;
	string testName;
	int errors = 0;
	int errorsAtStart = 0;
	int cyclesRun = 0;
	int cyclesAtStart = 0;
	int testsRun = 0;

	memSys memSys_inst (.*);

	sramModel #(.fillKey(16'h3c00)) ram1Chip (
		.addr(ram1Addr),
		.dataIn(ram1Dout),
		.dataOe(ram1Doe),
		.dataOut(ram1Din),
		.en(ram1En),
		.oe(ram1Oe),
		.we(ram1We)
	);

	sramModel #(.fillKey(16'h81a5)) ram2Chip (
		.addr(ram2Addr),
		.dataIn(ram2Dout),
		.dataOe(ram2Doe),
		.dataOut(ram2Din),
		.en(ram2En),
		.oe(ram2Oe),
		.we(ram2We)
	);

	uartModel uartChip (
		.dataIn(uartDout),
		.dataOe(uartDoe),
		.rdn(rdn),
		.wrn(wrn),
		.dataOut(uartDin),
		.dataReady(dataReady),
		.rxReady(rxReady),
		.rxByte(rxByte),
		.txLast(txLast),
		.txCount(txCount)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Upper half of the state since the low bits repeat too soon
	function automatic logic [15:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic logic [15:0] fillWord(input logic [15:0] key, input logic [17:0] a);
		return key ^ {a[7:0], a[15:8]} ^ {a[17:16], 14'h0000};
	endfunction

	// Kind 0 fetch only, 1 RAM1, 2 RAM2, 3 COM data, 4 COM command
	function automatic logic [15:0] pickAddr(input int kind);
		logic [15:0] r;
		logic [15:0] a;
		r = lcgNext();
		case (kind)
			1: a = {1'b0, r[14:0]};
			2: begin
				a = {1'b1, r[14:0]};
				if (a >= `COM1_DATA && a <= `COM2_COMMAND)
					a = 16'hC000;
			end
			3: a = r[15] ? `COM2_DATA : `COM1_DATA;
			4: a = r[15] ? `COM2_COMMAND : `COM1_COMMAND;
			default: a = r;
		endcase
		return a;
	endfunction

	task automatic reportValue(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		errors++;
		$display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
	endtask

	task automatic reportProblem(input string msg);
		errors++;
		$display("Error in test %s: %s", testName, msg);
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errors;
		cyclesAtStart = cyclesRun;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errors == errorsAtStart)
			$display("test %s ok, %0d cycles", testName, cyclesRun - cyclesAtStart);
		else
			$display("test %s has %0d errors", testName, errors - errorsAtStart);
	endtask

	// Samples 2 ns after each edge until the cycle ends
	task automatic waitAccess(output int waited, output logic sawStall);
		waited = 0;
		sawStall = 1'b0;
		while (waited < accessTimeout) begin
			@(posedge clk);
			#2;
			waited++;
			if (!noStop)
				sawStall = 1'b1;
			if (accessDone)
				break;
		end
		if (!accessDone) begin
			errors++;
			$display("Timeout in test %s: accessDone did not arrive within %0d cycles",
				testName, accessTimeout);
			$display("Regression failed");
			$finish;
		end
	endtask

	//////////////////////////////
	// One CPU memory cycle
	//////////////////////////////

	task automatic runCycle(input int kind, input logic isWrite, input logic [15:0] a);
		logic [15:0] r;
		logic [15:0] d;
		logic [15:0] p;
		logic [15:0] expData;
		logic [15:0] expInstr;
		logic expConflict;
		logic sawStall;
		int waited;
		d = lcgNext();
		p = lcgNext();
		r = lcgNext();
		rxReady = r[15];
		tbre = r[14];
		tsre = r[13];
		rxByte = r[7:0];
		expConflict = (kind == 1) || (kind >= 3);
		expInstr = expConflict ? `NOP_INSTR : refRam1[p];
		expData = 16'h0000;
		case (kind)
			1: begin
				if (isWrite)
					refRam1[a] = d;
				else
					expData = refRam1[a];
			end
			2: begin
				if (isWrite)
					refRam2[a] = d;
				else
					expData = refRam2[a];
			end
			3: begin
				if (isWrite)
					txSent.push_back(d[7:0]);
				else if (rxReady)
					expData = {8'h00, rxByte};
			end
			4: begin
				if (rxReady && tbre && tsre)
					expData = `STATUS_BOTH;
				else if (rxReady)
					expData = `STATUS_READ;
				else if (tbre && tsre)
					expData = `STATUS_WRITE;
			end
			default: ;
		endcase
		pc = p;
		address = a;
		writeData = d;
		memRead = (kind != 0) && !isWrite;
		memWrite = (kind != 0) && isWrite;
		waitAccess(waited, sawStall);
		cyclesRun++;
		if (memConflict !== expConflict)
			reportValue("memConflict", {15'h0, expConflict}, {15'h0, memConflict});
		if (instruct !== expInstr)
			reportValue("instruct", expInstr, instruct);
		if (kind != 0 && !isWrite && readData !== expData)
			reportValue("readData", expData, readData);
		if (kind <= 2 && waited - 1 != 3)
			reportValue("latency", 16'd3, 16'(waited - 1));
		if (kind <= 2 && sawStall)
			reportProblem("noStop went low during a cycle without UART access");
		if (kind == 3 && !sawStall)
			reportProblem("noStop never went low during a UART data access");
		if (kind == 3 && isWrite && txCount != txSent.size())
			reportProblem("the UART model did not receive the written byte");
		else if (kind == 3 && isWrite && txLast !== txSent[$])
			reportValue("txByte", {8'h00, txSent[$]}, {8'h00, txLast});
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : mainFlow
		int kind;
		int waited;
		logic stall;
		logic [15:0] r;
		logic [15:0] a;
		rst = 1'b0;
		pc = 16'h0000;
		address = 16'h0000;
		writeData = 16'h0000;
		memRead = 1'b0;
		memWrite = 1'b0;
		tbre = 1'b0;
		tsre = 1'b0;
		rxReady = 1'b0;
		rxByte = 8'h00;
		for (int i = 0; i < 65536; i++) begin
			refRam1[i] = fillWord(16'h3c00, {2'b00, i[15:0]});
			refRam2[i] = fillWord(16'h81a5, {2'b00, i[15:0]});
		end

		// Idle levels while reset is held
		repeat (4) @(posedge clk);
		#2;
		startTest("resetIdle");
		if ({ram1En, ram1Oe, ram1We, ram2En, ram2Oe, ram2We, rdn, wrn} !== 8'hFF)
			reportProblem("an SRAM or UART strobe is not high after reset");
		if (ram1Doe || ram2Doe || uartDoe)
			reportProblem("an output enable is active after reset");
		if (noStop !== 1'b1 || accessDone !== 1'b0 || memConflict !== 1'b0)
			reportProblem("noStop, accessDone or memConflict is not idle after reset");
		rst = 1'b1;
		waitAccess(waited, stall);
		if (instruct !== refRam1[0])
			reportValue("instruct", refRam1[0], instruct);
		finishTest();

		// Write then read back at the same address half the time
		startTest("ramData");
		repeat (40) begin
			r = lcgNext();
			kind = r[15] ? 1 : 2;
			a = pickAddr(kind);
			runCycle(kind, 1'b1, a);
			runCycle(kind, 1'b0, r[14] ? a : pickAddr(kind));
		end
		finishTest();

		startTest("fetch");
		repeat (40) begin
			r = lcgNext();
			kind = (r[15:14] == 2'd3) ? 1 : (r[15] ? 2 : 0);
			runCycle(kind, r[13], pickAddr(kind));
		end
		finishTest();

		startTest("uartData");
		repeat (30) begin
			r = lcgNext();
			runCycle(3, r[15], pickAddr(3));
		end
		finishTest();

		startTest("uartStatus");
		repeat (20) runCycle(4, 1'b0, pickAddr(4));
		finishTest();

		startTest("mixed");
		repeat (60) begin
			r = lcgNext();
			kind = int'(r[15:8]) % 5;
			runCycle(kind, r[3] && kind != 4, pickAddr(kind));
		end
		finishTest();

		$display("Summary: %0d tests, %0d cycles, %0d errors", testsRun, cyclesRun, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== memSys_tbModels.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

//////////////////////////////
// Asynchronous SRAM chip
//////////////////////////////

module sramModel #(
	parameter logic [15:0] fillKey = 16'h0000
) (
	input logic [`SRAM_ADDR_W-1:0] addr,
	input logic [15:0] dataIn,
	input logic dataOe,
	output logic [15:0] dataOut,
	input logic en,
	input logic oe,
	input logic we
);
	localparam int depth = 1 << `SRAM_ADDR_W;

	logic [15:0] mem [depth];

	// Power-up contents depend on every address bit
	initial begin
		logic [17:0] a;
		for (int i = 0; i < depth; i++) begin
			a = i[17:0];
			mem[a] = fillKey ^ {a[7:0], a[15:8]} ^ {a[17:16], 14'h0000};
		end
	end

	assign dataOut = (!en && !oe) ? mem[addr] : 16'h0000;

	// Word lands when we rises while the bus is still driven
	always @(posedge we) begin
		if (dataOe)
			mem[addr] <= dataIn;
	end

endmodule

//////////////////////////////
// Byte-wide UART chip
//////////////////////////////

module uartModel (
	input logic [7:0] dataIn,
	input logic dataOe,
	input logic rdn,
	input logic wrn,
	output logic [7:0] dataOut,
	output logic dataReady,
	input logic rxReady,
	input logic [7:0] rxByte,
	output logic [7:0] txLast,
	output int txCount
);
	assign dataReady = rxReady;
	assign dataOut = !rdn ? rxByte : 8'h00;

	initial begin
		txLast = 8'h00;
		txCount = 0;
	end

	// Transmit byte taken on the end of the write strobe
	always @(posedge wrn) begin
		if (dataOe) begin
			txLast <= dataIn;
			txCount <= txCount + 1;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/bash
# Compile the memSys testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
	--top-module memSys_tb \
	-f memSys.f \
	-o memSysSim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/memSysSim > sim.log 2>&1
cat sim.log

grep -qx "Regression passed" sim.log \
	&& echo "Simulation result: pass" \
	|| { echo "Simulation result: fail"; exit 1; }

exit 0

// ==== sramBankCtrl.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module sramBankCtrl (
	input logic clk,
	input logic rst,
	input memSysPkg::bankReqT req,
	output memSysPkg::bankRespT resp,
	output logic [`SRAM_ADDR_W-1:0] sramAddr,
	output logic [15:0] sramDout,
	output logic sramDoe,
	output logic sramEn,
	output logic sramOe,
	output logic sramWe,
	input logic [15:0] sramDin
);
	import memSysPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stAccess,
		stHold
	} bankStateT;

	bankStateT state;
	logic isWrite;
	logic doneReg;
	logic [15:0] readWord;

	assign resp = '{done: doneReg, data: readWord};

	//////////////////////////////
	// Chip sequencer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= stIdle;
			sramEn <= 1'b1;
			sramOe <= 1'b1;
			sramWe <= 1'b1;
			sramDoe <= 1'b0;
			doneReg <= 1'b0;
		end else begin
			doneReg <= 1'b0;
			case (state)
				stIdle: begin
					if (req.valid) begin
						// Address and write word settle with the strobes
						sramAddr <= req.addr;
						sramDout <= req.data;
						isWrite <= req.write;
						sramEn <= 1'b0;
						sramOe <= req.write;
						sramWe <= !req.write;
						sramDoe <= req.write;
						state <= stAccess;
					end
				end
				stAccess: begin
					if (!isWrite)
						readWord <= sramDin;
					// Rising we latches the word still on the bus
					sramEn <= 1'b1;
					sramOe <= 1'b1;
					sramWe <= 1'b1;
					doneReg <= 1'b1;
					state <= stHold;
				end
				stHold: begin
					sramDoe <= 1'b0;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== uartPortCtrl.sv ====
`timescale 1ns/1ns
`include "memSys_defines.svh"

module uartPortCtrl (
	input logic clk,
	input logic rst,
	input memSysPkg::uartReqT req,
	output memSysPkg::uartRespT resp,
	output logic [7:0] uartDout,
	output logic uartDoe,
	output logic rdn,
	output logic wrn,
	input logic [7:0] uartDin,
	input logic dataReady,
	input logic tbre,
	input logic tsre
);
	import memSysPkg::*;

	localparam int countWidth = $clog2(`UART_STROBE_CYCLES);

	typedef enum logic [1:0] {
		stIdle,
		stHold,
		stStrobe,
		stRelease
	} uartStateT;

	uartStateT state;
	logic [countWidth-1:0] strobeCount;
	logic isWrite;
	logic doneReg;
	logic [15:0] rxWord;
	uartStatusU statusWord;

	// Transmitter ready only once both buffers are empty
	always_comb begin
		statusWord.flags.reserved = '0;
		statusWord.flags.readReady = dataReady;
		statusWord.flags.writeReady = tbre & tsre;
	end

	assign resp = '{done: doneReg, data: rxWord};

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= stIdle;
			rdn <= 1'b1;
			wrn <= 1'b1;
			uartDoe <= 1'b0;
			doneReg <= 1'b0;
		end else begin
			doneReg <= 1'b0;
			case (state)
				stIdle: begin
					if (req.valid) begin
						isWrite <= req.write;
						strobeCount <= countWidth'(`UART_STROBE_CYCLES - 1);
						if (req.isCommand) begin
							rxWord <= statusWord.raw;
							state <= stHold;
						end else if (req.write) begin
							uartDout <= req.data;
							uartDoe <= 1'b1;
							wrn <= 1'b0;
							state <= stStrobe;
						end else if (dataReady) begin
							rdn <= 1'b0;
							state <= stStrobe;
						end else begin
							// Nothing received yet
							rxWord <= 16'h0000;
							state <= stHold;
						end
					end
				end
				stHold: begin
					doneReg <= 1'b1;
					state <= stIdle;
				end
				stStrobe: begin
					if (strobeCount == '0) begin
						if (!isWrite)
							rxWord <= {8'h00, uartDin};
						rdn <= 1'b1;
						wrn <= 1'b1;
						doneReg <= 1'b1;
						state <= isWrite ? stRelease : stIdle;
					end else begin
						strobeCount <= strobeCount - 1'b1;
					end
				end
				stRelease: begin
					// Byte stays driven past the rising wrn
					uartDoe <= 1'b0;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule
